//--- src.f
+incdir+bench
logic/mac_stat_pkg.sv
logic/mgmt_map_pkg.sv
logic/report_intake.sv
logic/stat_channel.sv
logic/reg_read_port.sv
logic/mac_mgmt_top.sv
bench/tb_mac_mgmt.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_mac_mgmt \
    -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_mac_mgmt > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
# any failed check or a timeout prints the fail message
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

//--- bench/tb_checks.svh
//////////////////////////////
// protocol assertions
//////////////////////////////

function automatic void note_violation(input string what);
    $display("%s: %s", test_name, what);
    errors++;
endfunction

// resp trails valid by 4 cycles, both edges
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(rx_mgnt_valid) |-> ##4 $rose(rx_mgnt_resp))
    else note_violation("rx resp did not rise 4 cycles after valid");
assert property (@(posedge clk_if) disable iff (!rst_if)
    $fell(rx_mgnt_valid) |-> ##4 $fell(rx_mgnt_resp))
    else note_violation("rx resp did not fall 4 cycles after valid");
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(tx_mgnt_valid) |-> ##4 $rose(tx_mgnt_resp))
    else note_violation("tx resp did not rise 4 cycles after valid");
assert property (@(posedge clk_if) disable iff (!rst_if)
    $fell(tx_mgnt_valid) |-> ##4 $fell(tx_mgnt_resp))
    else note_violation("tx resp did not fall 4 cycles after valid");

// no resp without a report behind it
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(rx_mgnt_resp) |-> $past(rx_mgnt_valid, 4))
    else note_violation("rx resp rose without valid 4 cycles earlier");
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(tx_mgnt_resp) |-> $past(tx_mgnt_valid, 4))
    else note_violation("tx resp rose without valid 4 cycles earlier");

// burst starts 2 cycles after the command, N_BEATS long
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(read_cmd.valid) |-> ##2 $rose(resp_beat.data_valid))
    else note_violation("read burst did not start 2 cycles after the command");
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(resp_beat.data_valid) |->
        ##(N_BEATS - 1) resp_beat.data_valid ##1 !resp_beat.data_valid)
    else note_violation("read burst has the wrong number of beats");

// ack right after the last beat, released only with the command
assert property (@(posedge clk_if) disable iff (!rst_if)
    $rose(sys_req_ack) |-> $past(resp_beat.data_valid))
    else note_violation("ack rose without a beat just before it");
assert property (@(posedge clk_if) disable iff (!rst_if)
    $fell(sys_req_ack) |-> !read_cmd.valid)
    else note_violation("ack fell while the command was still valid");

// outputs quiet after any reset cycle
assert property (@(posedge clk_if)
    !rst_if |=> !rx_mgnt_resp && !tx_mgnt_resp && !sys_req_ack && !resp_beat.data_valid)
    else note_violation("handshake outputs not low after reset");

//////////////////////////////
// bus drivers
//////////////////////////////

// 2 ns past the next rising edge
task automatic tick();
    @(posedge clk_if);
    #2;
endtask

function automatic logic resp_of(input int chan);
    return (chan == CHAN_RX) ? rx_mgnt_resp : tx_mgnt_resp;
endfunction

// one full report handshake
task automatic send_report(input int chan, input logic [19:0] word);
    tick();
    if (chan == CHAN_RX) begin
        rx_mgnt_valid = 1'b1;
        rx_mgnt_data  = rx_view_t'(word);
    end
    else begin
        tx_mgnt_valid = 1'b1;
        tx_mgnt_data  = tx_view_t'(word);
    end
    do tick(); while (!resp_of(chan));
    rx_mgnt_valid = 1'b0;
    tx_mgnt_valid = 1'b0;
    do tick(); while (resp_of(chan));
endtask

// collects the beats msb first until ack
task automatic read_addr(input addr_t addr, output logic [CNT_WIDTH-1:0] value,
                         output int beats);
    value = '0;
    beats = 0;
    tick();
    read_cmd.valid = 1'b1;
    read_cmd.addr  = addr;
    tick();
    while (!sys_req_ack) begin
        if (resp_beat.data_valid) begin
            value = (value << 8) | CNT_WIDTH'(resp_beat.data);
            beats++;
        end
        tick();
    end
    // command held a little past ack, ack has to stay up meanwhile
    repeat (2) tick();
    read_cmd.valid = 1'b0;
    while (sys_req_ack) tick();
endtask

//--- bench/tb_mac_mgmt.sv
`timescale 1ns/1ns

module tb_mac_mgmt import mac_stat_pkg::*; import mgmt_map_pkg::*; ();

    localparam int CNT_WIDTH = 32;
    localparam int N_BEATS   = CNT_WIDTH / 8;
    // ~130 reads and reports at under 20 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 4000;

    // transmit addresses in map order
    localparam addr_t TX_ADDRS [6] = '{ADDR_TX_PKT, ADDR_TX_BYTE, ADDR_TX_TTE,
                                       ADDR_TX_1588, ADDR_TX_VLAN, ADDR_TX_FC};

    logic       clk_if;
    logic       rst_if;
    logic       rx_mgnt_valid;
    rx_view_t   rx_mgnt_data;
    logic       rx_mgnt_resp;
    logic       tx_mgnt_valid;
    tx_view_t   tx_mgnt_data;
    logic       tx_mgnt_resp;
    read_cmd_t  read_cmd;
    logic       sys_req_ack;
    resp_beat_t resp_beat;

    // run bookkeeping
    string test_name = "reset";
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    int    cycles;

    // expected counters, channel by slot
    logic [CNT_WIDTH-1:0] model_cnt [N_CHAN][N_SLOTS];

    mac_mgmt_top #(
        .CNT_WIDTH (CNT_WIDTH)
    ) UUT (
        .clk_if        (clk_if),
        .rst_if        (rst_if),
        .rx_mgnt_valid (rx_mgnt_valid),
        .rx_mgnt_data  (rx_mgnt_data),
        .rx_mgnt_resp  (rx_mgnt_resp),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .read_cmd      (read_cmd),
        .sys_req_ack   (sys_req_ack),
        .resp_beat     (resp_beat)
    );

    `include "tb_checks.svh"

    initial begin
        clk_if = 1'b0;
        forever #10 clk_if = ~clk_if;
    end

    // watchdog
    always @(posedge clk_if) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    // clean frames count, every set flag bit counts in slot 2+k
    function automatic void model_apply(input int chan, input logic [19:0] word);
        logic [7:0] fl;
        fl = word[19:12];
        if (fl[7:4] == 4'h0) begin
            model_cnt[chan][SLOT_PKT]  += 1;
            model_cnt[chan][SLOT_BYTE] += CNT_WIDTH'(word[11:0]);
        end
        for (int k = 0; k < 8; k++) begin
            if (fl[k]) model_cnt[chan][SLOT_FLAG0 + k] += 1;
        end
    endfunction

    function automatic logic [CNT_WIDTH-1:0] expected_at(input addr_t addr);
        case (addr)
            ADDR_TX_PKT:  return model_cnt[CHAN_TX][0];
            ADDR_TX_BYTE: return model_cnt[CHAN_TX][1];
            ADDR_TX_TTE:  return model_cnt[CHAN_TX][5];
            ADDR_TX_1588: return model_cnt[CHAN_TX][4];
            ADDR_TX_VLAN: return model_cnt[CHAN_TX][2];
            ADDR_TX_FC:   return model_cnt[CHAN_TX][3];
            // rx address n is rx slot n, the rest is unmapped
            default: return (addr <= ADDR_RX_BP) ? model_cnt[CHAN_RX][int'(addr)] : '0;
        endcase
    endfunction

    task automatic report_frame(input int chan, input logic [19:0] word);
        send_report(chan, word);
        model_apply(chan, word);
    endtask

    task automatic check_addr(input addr_t addr);
        logic [CNT_WIDTH-1:0] got;
        logic [CNT_WIDTH-1:0] exp;
        int                   beats;
        exp = expected_at(addr);
        read_addr(addr, got, beats);
        assert (beats == N_BEATS) else begin
            $display("ERROR %s: beats at 0x%02h expected %0d actual %0d",
                     test_name, addr, N_BEATS, beats);
            errors++;
        end
        assert (got === exp) else begin
            $display("ERROR %s: counter at 0x%02h expected 0x%h actual 0x%h",
                     test_name, addr, exp, got);
            errors++;
        end
    endtask

    task automatic check_bank(input int chan);
        if (chan == CHAN_RX) begin
            for (int a = ADDR_RX_PKT; a <= ADDR_RX_BP; a++) begin
                check_addr(addr_t'(a));
            end
        end
        else begin
            foreach (TX_ADDRS[i]) check_addr(TX_ADDRS[i]);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end
        else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        int          chan;
        logic [19:0] word;
        void'($urandom(32'ha31a_38cd));
        rst_if        = 1'b0;
        rx_mgnt_valid = 1'b0;
        rx_mgnt_data  = '0;
        tx_mgnt_valid = 1'b0;
        tx_mgnt_data  = '0;
        read_cmd      = '0;
        foreach (model_cnt[c, s]) model_cnt[c][s] = '0;
        repeat (5) @(posedge clk_if);
        #2;
        rst_if = 1'b1;

        begin_test("reset_zero");
        assert (!rx_mgnt_resp && !tx_mgnt_resp && !sys_req_ack && !resp_beat.data_valid)
        else begin
            $display("%s: handshake outputs are not low after reset", test_name);
            errors++;
        end
        check_bank(CHAN_RX);
        check_bank(CHAN_TX);
        check_addr(8'h0A);
        end_test();

        // type flags only, every frame counts
        begin_test("rx_clean");
        repeat (6) report_frame(CHAN_RX, {4'h0, 4'($urandom), 12'($urandom)});
        check_bank(CHAN_RX);
        end_test();

        // at least one error flag per frame
        begin_test("rx_errors");
        repeat (5) report_frame(CHAN_RX, {4'($urandom_range(15, 1)), 4'($urandom),
                                          12'($urandom)});
        check_bank(CHAN_RX);
        end_test();

        // each tx flag alone first, then random
        begin_test("tx_flags");
        for (int k = 0; k < 6; k++) begin
            word = {4'h0, (k < 4) ? 4'(1 << k) : 4'($urandom), 12'($urandom)};
            report_frame(CHAN_TX, word);
        end
        check_bank(CHAN_TX);
        check_bank(CHAN_RX);
        end_test();

        // multi-byte values and unmapped holes
        begin_test("read_burst");
        check_addr(ADDR_RX_BYTE);
        check_addr(ADDR_TX_BYTE);
        check_addr(8'h0A);
        check_addr(8'h16);
        check_addr(8'hFF);
        end_test();

        begin_test("random_mix");
        repeat (40) begin
            chan = int'($urandom_range(1, 0));
            word = 20'($urandom);
            // tx error nibble is always zero
            if (chan == CHAN_TX) word[19:16] = 4'h0;
            report_frame(chan, word);
        end
        check_bank(CHAN_RX);
        check_bank(CHAN_TX);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- logic/mac_mgmt_top.sv
`timescale 1ns/1ns

module mac_mgmt_top import mac_stat_pkg::*; import mgmt_map_pkg::*; #(
    parameter int CNT_WIDTH = 32
) (
    input  logic       clk_if,
    input  logic       rst_if,
    // receive report port
    input  logic       rx_mgnt_valid,
    input  rx_view_t   rx_mgnt_data,
    output logic       rx_mgnt_resp,
    // transmit report port
    input  logic       tx_mgnt_valid,
    input  tx_view_t   tx_mgnt_data,
    output logic       tx_mgnt_resp,
    // system command port
    input  read_cmd_t  read_cmd,
    output logic       sys_req_ack,
    output resp_beat_t resp_beat
);

    report_evt_t [N_CHAN-1:0]                             report_evt;
    logic        [N_CHAN-1:0][N_SLOTS-1:0][CNT_WIDTH-1:0] bank_cnt;

    // report handshakes, one event per frame
    report_intake u_intake (
        .clk_if        (clk_if),
        .rst_if        (rst_if),
        .rx_mgnt_valid (rx_mgnt_valid),
        .rx_mgnt_data  (rx_mgnt_data),
        .rx_mgnt_resp  (rx_mgnt_resp),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .report_evt    (report_evt)
    );

    //////////////////////////////
    // one bank per direction
    //////////////////////////////

    for (genvar c = 0; c < N_CHAN; c++) begin : g_bank
        stat_channel #(
            .CNT_WIDTH (CNT_WIDTH)
        ) u_chan (
            .clk_if     (clk_if),
            .rst_if     (rst_if),
            .report_evt (report_evt[c]),
            .counters   (bank_cnt[c])
        );
    end

    // reads across both banks
    reg_read_port #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_read (
        .clk_if      (clk_if),
        .rst_if      (rst_if),
        .read_cmd    (read_cmd),
        .counters    (bank_cnt),
        .sys_req_ack (sys_req_ack),
        .resp_beat   (resp_beat)
    );

endmodule

//--- logic/reg_read_port.sv
`timescale 1ns/1ns

module reg_read_port import mac_stat_pkg::*; import mgmt_map_pkg::*; #(
    // multiple of 8, one beat per byte
    parameter int CNT_WIDTH = 32
) (
    input  logic                                          clk_if,
    input  logic                                          rst_if,
    input  read_cmd_t                                     read_cmd,
    input  logic [N_CHAN-1:0][N_SLOTS-1:0][CNT_WIDTH-1:0] counters,
    output logic                                          sys_req_ack,
    output resp_beat_t                                    resp_beat
);

    localparam int N_BEATS = CNT_WIDTH / 8;
    localparam int BEAT_W  = (N_BEATS > 1) ? $clog2(N_BEATS) : 1;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(N_BEATS - 1);

    // command states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;
    localparam logic [1:0] ST_SHIFT = 2'd2;
    localparam logic [1:0] ST_ACK   = 2'd3;

    logic [1:0]           state_q;
    logic [1:0]           state_nxt;
    addr_t                addr_q;
    logic                 sel_hit;
    chan_idx_t            sel_chan;
    slot_idx_t            sel_slot;
    logic [CNT_WIDTH-1:0] shift_q;
    logic [BEAT_W-1:0]    beat_q;

    //////////////////////////////
    // address decode
    //////////////////////////////

    always_comb begin
        sel_hit  = 1'b1;
        sel_slot = slot_idx_t'(SLOT_PKT);
        case (addr_q)
            ADDR_RX_PKT,  ADDR_TX_PKT:  sel_slot = slot_idx_t'(SLOT_PKT);
            ADDR_RX_BYTE, ADDR_TX_BYTE: sel_slot = slot_idx_t'(SLOT_BYTE);
            ADDR_RX_VLAN, ADDR_TX_VLAN: sel_slot = slot_idx_t'(SLOT_FLAG0);
            // lldp on rx, fc on tx share word bit 13
            ADDR_RX_LLDP, ADDR_TX_FC:   sel_slot = slot_idx_t'(SLOT_FLAG0 + 1);
            ADDR_RX_1588, ADDR_TX_1588: sel_slot = slot_idx_t'(SLOT_FLAG0 + 2);
            ADDR_RX_TTE,  ADDR_TX_TTE:  sel_slot = slot_idx_t'(SLOT_FLAG0 + 3);
            // rx error counters
            ADDR_RX_FCS:  sel_slot = slot_idx_t'(SLOT_FLAG0 + 4);
            ADDR_RX_RUNT: sel_slot = slot_idx_t'(SLOT_FLAG0 + 5);
            ADDR_RX_JABR: sel_slot = slot_idx_t'(SLOT_FLAG0 + 6);
            ADDR_RX_BP:   sel_slot = slot_idx_t'(SLOT_FLAG0 + 7);
            // unmapped reads zero
            default:      sel_hit  = 1'b0;
        endcase
    end

    always_comb begin
        case (addr_q)
            ADDR_TX_PKT, ADDR_TX_BYTE, ADDR_TX_TTE,
            ADDR_TX_1588, ADDR_TX_VLAN, ADDR_TX_FC: sel_chan = chan_idx_t'(CHAN_TX);
            default:                                sel_chan = chan_idx_t'(CHAN_RX);
        endcase
    end

    //////////////////////////////
    // command FSM
    //////////////////////////////

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE:  if (read_cmd.valid) state_nxt = ST_LOAD;
            ST_LOAD:  state_nxt = ST_SHIFT;
            ST_SHIFT: if (beat_q == LAST_BEAT) state_nxt = ST_ACK;
            // hold ack until the requester lets go
            ST_ACK:   if (!read_cmd.valid) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end
        else begin
            state_q <= state_nxt;
            if (state_q == ST_LOAD) begin
                beat_q <= '0;
            end
            else if (state_q == ST_SHIFT) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // address latch and byte serializer
    always_ff @(posedge clk_if) begin
        if (state_q == ST_IDLE && read_cmd.valid) begin
            addr_q <= read_cmd.addr;
        end
        if (state_q == ST_LOAD) begin
            // snapshot, counters keep running meanwhile
            shift_q <= sel_hit ? counters[sel_chan][sel_slot] : '0;
        end
        else if (state_q == ST_SHIFT) begin
            shift_q <= shift_q << 8;
        end
    end

    // msb first
    assign resp_beat.data_valid = (state_q == ST_SHIFT);
    assign resp_beat.data       = shift_q[CNT_WIDTH-1 -: 8];
    assign sys_req_ack          = (state_q == ST_ACK);

endmodule

//--- logic/stat_channel.sv
`timescale 1ns/1ns

module stat_channel import mac_stat_pkg::*; #(
    parameter int CNT_WIDTH = 32
) (
    input  logic                              clk_if,
    input  logic                              rst_if,
    input  report_evt_t                       report_evt,
    output logic [N_SLOTS-1:0][CNT_WIDTH-1:0] counters
);

    rx_view_t view;
    flags_t   flags;
    logic     count_pkt;

    // both directions decode through the rx view
    assign view = report_evt.word.rx;

    // bit k of flags is word bit 12+k
    assign flags = {view.err_bp,
                    view.err_jabber,
                    view.err_runt,
                    view.err_fcs,
                    view.flag_tte,
                    view.flag_1588,
                    view.flag_lldp,
                    view.flag_vlan};

    // clean frame only
    // tx pads the error nibble with zeros, so tx frames always count
    assign count_pkt = ((flags & FLAG_ERR_MASK) == '0);

    //////////////////////////////
    // counter bank
    //////////////////////////////

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            counters <= '0;
        end
        else if (report_evt.strobe) begin
            if (count_pkt) begin
                counters[SLOT_PKT]  <= counters[SLOT_PKT] + 1'b1;
                // length zero-extended, sum wraps
                counters[SLOT_BYTE] <= counters[SLOT_BYTE] + CNT_WIDTH'(view.len);
            end
            // one slot per flag bit
            for (int k = 0; k < $bits(flags_t); k++) begin
                if (flags[k]) begin
                    counters[SLOT_FLAG0 + k] <= counters[SLOT_FLAG0 + k] + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/report_intake.sv
`timescale 1ns/1ns

module report_intake import mac_stat_pkg::*; (
    input  logic                     clk_if,
    input  logic                     rst_if,
    // receive report port
    input  logic                     rx_mgnt_valid,
    input  rx_view_t                 rx_mgnt_data,
    output logic                     rx_mgnt_resp,
    // transmit report port
    input  logic                     tx_mgnt_valid,
    input  tx_view_t                 tx_mgnt_data,
    output logic                     tx_mgnt_resp,
    // events to the counter banks
    output report_evt_t [N_CHAN-1:0] report_evt
);

    // handshake states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CAPT = 2'd1;
    localparam logic [1:0] ST_HOLD = 2'd2;

    logic         [N_CHAN-1:0]      valid_in;
    report_word_u [N_CHAN-1:0]      word_in;
    logic         [N_CHAN-1:0][1:0] sync_q;
    logic         [N_CHAN-1:0][1:0] state_q;
    logic         [N_CHAN-1:0][1:0] state_nxt;
    logic         [N_CHAN-1:0]      resp_q;
    report_word_u [N_CHAN-1:0]      capt_q;

    // both ports as one indexed set
    always_comb begin
        valid_in[CHAN_RX]   = rx_mgnt_valid;
        valid_in[CHAN_TX]   = tx_mgnt_valid;
        word_in[CHAN_RX].rx = rx_mgnt_data;
        // tx word enters through its own view
        word_in[CHAN_TX].tx = tx_mgnt_data;
    end

    //////////////////////////////
    // handshake machines
    //////////////////////////////

    always_comb begin
        for (int c = 0; c < N_CHAN; c++) begin
            state_nxt[c] = state_q[c];
            case (state_q[c])
                ST_IDLE: if (sync_q[c][1]) state_nxt[c] = ST_CAPT;
                // one cycle, strobe out
                ST_CAPT: state_nxt[c] = ST_HOLD;
                // wait for source to drop valid
                ST_HOLD: if (!sync_q[c][1]) state_nxt[c] = ST_IDLE;
                default: state_nxt[c] = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            sync_q  <= '0;
            state_q <= {N_CHAN{ST_IDLE}};
            resp_q  <= '0;
        end
        else begin
            for (int c = 0; c < N_CHAN; c++) begin
                // two-flop synchronizer
                sync_q[c]  <= {sync_q[c][0], valid_in[c]};
                state_q[c] <= state_nxt[c];
                // lags the state by one, so rise and fall are both 4 cycles
                resp_q[c]  <= (state_q[c] != ST_IDLE);
            end
        end
    end

    // word is stable while valid is up and resp still low
    always_ff @(posedge clk_if) begin
        for (int c = 0; c < N_CHAN; c++) begin
            if (state_q[c] == ST_IDLE && sync_q[c][1]) begin
                capt_q[c] <= word_in[c];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < N_CHAN; c++) begin
            report_evt[c].strobe = (state_q[c] == ST_CAPT);
            report_evt[c].word   = capt_q[c];
        end
    end

    assign rx_mgnt_resp = resp_q[CHAN_RX];
    assign tx_mgnt_resp = resp_q[CHAN_TX];

endmodule

//--- logic/mgmt_map_pkg.sv
package mgmt_map_pkg;

    //////////////////////////////
    // register address map
    //////////////////////////////

    typedef logic [7:0] addr_t;

    // receive bank, address n reads slot n
    localparam addr_t ADDR_RX_PKT  = 8'h00;
    localparam addr_t ADDR_RX_BYTE = 8'h01;
    localparam addr_t ADDR_RX_VLAN = 8'h02;
    localparam addr_t ADDR_RX_LLDP = 8'h03;
    localparam addr_t ADDR_RX_1588 = 8'h04;
    localparam addr_t ADDR_RX_TTE  = 8'h05;
    localparam addr_t ADDR_RX_FCS  = 8'h06;
    localparam addr_t ADDR_RX_RUNT = 8'h07;
    localparam addr_t ADDR_RX_JABR = 8'h08;
    localparam addr_t ADDR_RX_BP   = 8'h09;

    // transmit bank, flag order differs from the slot order
    localparam addr_t ADDR_TX_PKT  = 8'h10;
    localparam addr_t ADDR_TX_BYTE = 8'h11;
    localparam addr_t ADDR_TX_TTE  = 8'h12;
    localparam addr_t ADDR_TX_1588 = 8'h13;
    localparam addr_t ADDR_TX_VLAN = 8'h14;
    localparam addr_t ADDR_TX_FC   = 8'h15;

    //////////////////////////////
    // command and response
    //////////////////////////////

    // held by the requester until ack
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } read_cmd_t;

    // one byte of the read burst
    typedef struct packed {
        logic       data_valid;
        logic [7:0] data;
    } resp_beat_t;

endpackage

//--- logic/mac_stat_pkg.sv
package mac_stat_pkg;

    //////////////////////////////
    // report word fields
    //////////////////////////////

    // frame length in bytes
    typedef logic [11:0] len_t;

    // upper byte of a report, bit k sits at word bit 12+k
    typedef logic [7:0] flags_t;

    // receive view, error flags on top
    typedef struct packed {
        logic err_bp;
        logic err_jabber;
        logic err_runt;
        logic err_fcs;
        logic flag_tte;
        logic flag_1588;
        logic flag_lldp;
        logic flag_vlan;
        len_t len;
    } rx_view_t;

    // transmit view, no error flags
    typedef struct packed {
        logic [3:0] zero_pad;
        logic       flag_tte;
        logic       flag_1588;
        logic       flag_fc;
        logic       flag_vlan;
        len_t       len;
    } tx_view_t;

    // same 20 bits, two decodings
    typedef union packed {
        rx_view_t rx;
        tx_view_t tx;
    } report_word_u;

    // one-cycle strobe into a counter bank
    typedef struct packed {
        logic         strobe;
        report_word_u word;
    } report_evt_t;

    // error flags, upper nibble of the rx view
    localparam flags_t FLAG_ERR_MASK = 8'hF0;

    //////////////////////////////
    // counter slots and channels
    //////////////////////////////

    localparam int N_SLOTS    = 10;
    localparam int SLOT_PKT   = 0;
    localparam int SLOT_BYTE  = 1;
    // flag bit k counts in slot SLOT_FLAG0+k
    localparam int SLOT_FLAG0 = 2;

    typedef logic [$clog2(N_SLOTS)-1:0] slot_idx_t;

    localparam int N_CHAN  = 2;
    localparam int CHAN_RX = 0;
    localparam int CHAN_TX = 1;

    typedef logic [$clog2(N_CHAN)-1:0] chan_idx_t;

endpackage
